// File: source/scratch_config.svh
// Depth may change through the address width, but the lane count must stay at 4 byte lanes
`ifndef SCRATCH_CONFIG_SVH
`define SCRATCH_CONFIG_SVH

// Word address width for 1024 words
`define SCRATCH_ADDR_W 10

// Byte lanes per word
// Data width is eight bits per lane, so 32 bits
`define SCRATCH_LANES 4

`endif

// File: source/scratch_pkg.sv
// Needs scratch_config.svh on the include path and derives the data width from the lane count
`include "scratch_config.svh"

package scratch_pkg;

  localparam int unsigned DATA_W = 8 * `SCRATCH_LANES;

  // One RAM access as seen by byte_ram
  typedef struct packed {
    logic [`SCRATCH_LANES-1:0]  en;     // Lane enable
    logic [`SCRATCH_LANES-1:0]  we;     // Lane write enable
    logic [`SCRATCH_ADDR_W-1:0] addr;   // Word address
    logic [DATA_W-1:0]          wdata;
  } ram_req_t;

  // External host command
  typedef struct packed {
    logic                       write;  // 0 for a full-word read
    logic [`SCRATCH_LANES-1:0]  mask;   // Byte mask for writes
    logic [`SCRATCH_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]          data;
  } host_cmd_t;

  // Sum job over a word range
  typedef struct packed {
    logic [`SCRATCH_ADDR_W-1:0] base;
    logic [`SCRATCH_ADDR_W-1:0] count;  // Zero means an empty range
  } sum_cmd_t;

endpackage

// File: source/byte_ram.sv
// Write-first RAM with no reset, so contents power up unknown and disabled lanes keep old rdata
`timescale 1ns/1ns
`include "scratch_config.svh"

module byte_ram (
  input  logic                           clk,
  input  scratch_pkg::ram_req_t          req,
  output logic [scratch_pkg::DATA_W-1:0] rdata
);

  localparam int unsigned DEPTH = 1 << `SCRATCH_ADDR_W;

  // Word storage split into byte lanes
  logic [`SCRATCH_LANES-1:0][7:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    for (int i = 0; i < `SCRATCH_LANES; i++) begin
      if (req.en[i]) begin
        if (req.we[i]) begin
          mem[req.addr][i] <= req.wdata[8*i +: 8];
          rdata[8*i +: 8]  <= req.wdata[8*i +: 8];  // New byte straight out
        end else begin
          rdata[8*i +: 8] <= mem[req.addr][i];
        end
      end
      // Lane off leaves its rdata byte as it was
    end
  end

endmodule

// File: source/ram_arbiter.sv
// Two-master round-robin with a combinational grant, so requesters must hold their request
`timescale 1ns/1ns

module ram_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  host_rq,
  input  logic                  sum_rq,
  input  scratch_pkg::ram_req_t host_req,
  input  scratch_pkg::ram_req_t sum_req,
  output logic                  host_gnt,
  output logic                  sum_gnt,
  output scratch_pkg::ram_req_t ram_req
);

  logic last_sum;  // Sum engine won the last grant

  // Lone requester wins, on a tie the one that lost last time
  always_comb begin
    host_gnt = host_rq & (~sum_rq | last_sum);
    sum_gnt  = sum_rq & (~host_rq | ~last_sum);
  end

  always_comb begin
    ram_req = '0;  // Idle cycle carries no lane enables
    if (host_gnt) begin
      ram_req = host_req;
    end else if (sum_gnt) begin
      ram_req = sum_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_sum <= 1'b0;
    end else if (host_gnt) begin
      last_sum <= 1'b0;
    end else if (sum_gnt) begin
      last_sum <= 1'b1;
    end
  end

endmodule

// File: source/host_port.sv
// Holds one command at a time, and a new host_req is ignored while host_busy is high
`timescale 1ns/1ns

module host_port (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           host_req,
  input  scratch_pkg::host_cmd_t         host_cmd,
  output logic                           host_busy,
  output logic                           host_done,
  output logic [scratch_pkg::DATA_W-1:0] host_rdata,
  output logic                           rq,
  output scratch_pkg::ram_req_t          req,
  input  logic                           gnt,
  input  logic [scratch_pkg::DATA_W-1:0] ram_rdata
);

  scratch_pkg::host_cmd_t         cmd_q;
  logic                           pend;     // Waiting for a grant
  logic                           gnt_q;    // Granted last cycle
  logic [scratch_pkg::DATA_W-1:0] rdata_q;

  assign rq        = pend;
  assign host_busy = pend | gnt_q;  // Busy through the done cycle
  assign host_done = gnt_q;

  // Reads take every lane, writes take only the masked ones
  always_comb begin
    req.addr  = cmd_q.addr;
    req.wdata = cmd_q.data;
    req.en    = cmd_q.write ? cmd_q.mask : '1;
    req.we    = cmd_q.write ? cmd_q.mask : '0;
  end

  // RAM data is live during the done pulse and held afterwards
  assign host_rdata = (gnt_q && !cmd_q.write) ? ram_rdata : rdata_q;

  always_ff @(posedge clk) begin
    if (host_req && !host_busy) begin
      cmd_q <= host_cmd;
    end
    if (gnt_q && !cmd_q.write) begin
      rdata_q <= ram_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend  <= 1'b0;
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= pend & gnt;
      if (host_req && !host_busy) begin
        pend <= 1'b1;
      end else if (gnt) begin
        pend <= 1'b0;
      end
    end
  end

endmodule

// File: source/sum_engine.sv
// Reads full words in increasing address order, and the sum wraps at 32 bits with no overflow flag
`timescale 1ns/1ns
`include "scratch_config.svh"

module sum_engine (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           sum_start,
  input  scratch_pkg::sum_cmd_t          sum_cmd,
  output logic                           sum_busy,
  output logic                           sum_done,
  output logic [scratch_pkg::DATA_W-1:0] sum_result,
  output logic                           rq,
  output scratch_pkg::ram_req_t          req,
  input  logic                           gnt,
  input  logic [scratch_pkg::DATA_W-1:0] ram_rdata
);

  logic [`SCRATCH_ADDR_W-1:0]     issue_addr;  // Next word to read
  logic [`SCRATCH_ADDR_W-1:0]     remain;      // Words still to issue
  logic [scratch_pkg::DATA_W-1:0] acc;
  logic                           active;
  logic                           gnt_q;       // Data arrives this cycle
  logic                           last_q;      // That data is the final word
  logic                           done_q;
  logic                           accept;

  assign accept     = sum_start & ~active;
  assign rq         = active & (remain != '0);
  assign sum_busy   = active;
  assign sum_done   = done_q;
  assign sum_result = acc;

  // Always a full-word read
  always_comb begin
    req.en    = '1;
    req.we    = '0;
    req.addr  = issue_addr;
    req.wdata = '0;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_addr <= sum_cmd.base;
      remain     <= sum_cmd.count;
      acc        <= '0;
    end else begin
      if (rq && gnt) begin
        issue_addr <= issue_addr + 1'b1;  // Wraps at the top of the RAM
        remain     <= remain - 1'b1;
      end
      if (gnt_q) begin
        acc <= acc + ram_rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      gnt_q  <= 1'b0;
      last_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      gnt_q  <= rq & gnt;
      last_q <= rq & gnt & (remain == `SCRATCH_ADDR_W'(1));
      done_q <= 1'b0;
      if (accept) begin
        active <= (sum_cmd.count != '0);
        done_q <= (sum_cmd.count == '0);  // Empty range finishes at once
      end else if (gnt_q && last_q) begin
        active <= 1'b0;
        done_q <= 1'b1;                   // Final addition lands this edge
      end
    end
  end

endmodule

// File: source/scratch_top.sv
// Two masters share one RAM, and each master waits at most two cycles for a grant
`timescale 1ns/1ns

module scratch_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           host_req,
  input  scratch_pkg::host_cmd_t         host_cmd,
  output logic                           host_busy,
  output logic                           host_done,
  output logic [scratch_pkg::DATA_W-1:0] host_rdata,
  input  logic                           sum_start,
  input  scratch_pkg::sum_cmd_t          sum_cmd,
  output logic                           sum_busy,
  output logic                           sum_done,
  output logic [scratch_pkg::DATA_W-1:0] sum_result
);

  logic                           host_rq;
  logic                           sum_rq;
  logic                           host_gnt;
  logic                           sum_gnt;
  scratch_pkg::ram_req_t          host_ram_req;
  scratch_pkg::ram_req_t          sum_ram_req;
  scratch_pkg::ram_req_t          ram_req;
  logic [scratch_pkg::DATA_W-1:0] ram_rdata;  // Shared by both masters

  host_port u_host_port (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_cmd   (host_cmd),
    .host_busy  (host_busy),
    .host_done  (host_done),
    .host_rdata (host_rdata),
    .rq         (host_rq),
    .req        (host_ram_req),
    .gnt        (host_gnt),
    .ram_rdata  (ram_rdata)
  );

  sum_engine u_sum_engine (
    .clk        (clk),
    .rst        (rst),
    .sum_start  (sum_start),
    .sum_cmd    (sum_cmd),
    .sum_busy   (sum_busy),
    .sum_done   (sum_done),
    .sum_result (sum_result),
    .rq         (sum_rq),
    .req        (sum_ram_req),
    .gnt        (sum_gnt),
    .ram_rdata  (ram_rdata)
  );

  ram_arbiter u_ram_arbiter (
    .clk      (clk),
    .rst      (rst),
    .host_rq  (host_rq),
    .sum_rq   (sum_rq),
    .host_req (host_ram_req),
    .sum_req  (sum_ram_req),
    .host_gnt (host_gnt),
    .sum_gnt  (sum_gnt),
    .ram_req  (ram_req)
  );

  byte_ram u_byte_ram (
    .clk   (clk),
    .req   (ram_req),
    .rdata (ram_rdata)
  );

endmodule

// File: test/byte_ram_chk.sv
// Bound to every byte_ram, the RAM has no reset so lane checks skip cycles with unknown enables
`timescale 1ns/1ns
`include "scratch_config.svh"

module byte_ram_chk (
  input logic                           clk,
  input scratch_pkg::ram_req_t          req,
  input logic [scratch_pkg::DATA_W-1:0] rdata
);

  for (genvar i = 0; i < `SCRATCH_LANES; i++) begin : g_lane
    // Write-first, the new byte shows on rdata next cycle
    assert property (@(posedge clk)
      req.en[i] && req.we[i] |=> rdata[8*i +: 8] == $past(req.wdata[8*i +: 8]))
      else $error("byte_ram lane %0d did not return the written byte", i);

    assert property (@(posedge clk)
      !req.en[i] |=> rdata[8*i +: 8] === $past(rdata[8*i +: 8]))  // Idle lane holds
      else $error("byte_ram lane %0d changed rdata while disabled", i);
  end

endmodule

bind byte_ram byte_ram_chk u_ram_chk (
  .clk   (clk),
  .req   (req),
  .rdata (rdata)
);

// File: test/scratch_monitor.sv
// Checks only words whose bytes have all been written, and assumes one host command at a time
`timescale 1ns/1ns
`include "scratch_config.svh"

module scratch_monitor (
  input logic                           clk,
  input logic                           rst,
  input logic                           host_req,
  input scratch_pkg::host_cmd_t         host_cmd,
  input logic                           host_busy,
  input logic                           host_done,
  input logic [scratch_pkg::DATA_W-1:0] host_rdata,
  input logic                           sum_start,
  input scratch_pkg::sum_cmd_t          sum_cmd,
  input logic                           sum_busy,
  input logic                           sum_done,
  input logic [scratch_pkg::DATA_W-1:0] sum_result
);

  localparam int DEPTH = 1 << `SCRATCH_ADDR_W;

  logic [scratch_pkg::DATA_W-1:0] model [DEPTH];
  logic [`SCRATCH_LANES-1:0]      known [DEPTH];  // Bytes written so far
  scratch_pkg::host_cmd_t         host_cmd_q;     // Command now in flight
  scratch_pkg::sum_cmd_t          sum_cmd_q;
  int err_count;
  int check_count;
  int host_done_count;
  int sum_done_count;

  initial begin
    err_count       = 0;
    check_count     = 0;
    host_done_count = 0;
    sum_done_count  = 0;
    host_cmd_q      = '0;
    sum_cmd_q       = '0;
    for (int i = 0; i < DEPTH; i++) begin
      model[i] = '0;
      known[i] = '0;
    end
  end

  // Sampled mid-cycle, away from the edges where the DUT and stimulus change
  always @(negedge clk) begin
    logic [`SCRATCH_ADDR_W-1:0]     a;
    logic [scratch_pkg::DATA_W-1:0] exp_sum;
    logic                           all_known;
    if (!rst) begin
      if (host_req && !host_busy) begin
        host_cmd_q = host_cmd;
        if (host_cmd.write) begin
          for (int i = 0; i < `SCRATCH_LANES; i++) begin
            if (host_cmd.mask[i]) begin
              model[host_cmd.addr][8*i +: 8] = host_cmd.data[8*i +: 8];
              known[host_cmd.addr][i]        = 1'b1;
            end
          end
        end
      end
      if (host_done) begin
        host_done_count++;
        if (!host_cmd_q.write && known[host_cmd_q.addr] == '1) begin
          check_count++;
          if (host_rdata !== model[host_cmd_q.addr]) begin
            err_count++;
            $display("[ERROR] %0t: host read of word %0d returned %h, expected %h",
                     $time, host_cmd_q.addr, host_rdata, model[host_cmd_q.addr]);
          end
        end
      end
      if (sum_start && !sum_busy) sum_cmd_q = sum_cmd;
      if (sum_done) begin
        sum_done_count++;
        exp_sum   = '0;
        all_known = 1'b1;
        a         = sum_cmd_q.base;
        for (int n = 0; n < int'(sum_cmd_q.count); n++) begin
          exp_sum = exp_sum + model[a];  // Wraps at 32 bits
          if (known[a] != '1) all_known = 1'b0;
          a = a + 1'b1;
        end
        if (all_known) begin
          check_count++;
          if (sum_result !== exp_sum) begin
            err_count++;
            $display("[ERROR] %0t: sum of %0d words from %0d is %h, expected %h",
                     $time, sum_cmd_q.count, sum_cmd_q.base, sum_result, exp_sum);
          end
        end
      end
    end
  end

endmodule

// File: test/scratch_tb.sv
// Fixed seed gives a repeatable run, and the sum and host regions of test 5 must not overlap
`timescale 1ns/1ns
`include "scratch_config.svh"

module scratch_tb;

  localparam int AW         = `SCRATCH_ADDR_W;
  localparam int N_WORDS    = 48;   // Words filled by test 2
  localparam int N_MASK     = 32;
  localparam int N_SUM      = 6;
  localparam int N_MIX      = 24;
  localparam int MIX_BASE   = 512;  // Host region in test 5
  localparam int WAIT_LIMIT = 40;
  localparam int TXN_CYCLES = 10;   // Bound on one transaction
  localparam int TXN_TOTAL  = 1 + 2*N_WORDS + 2*N_MASK + N_SUM*(N_WORDS + 1) + N_MIX + N_WORDS;
  localparam int WATCHDOG_CYCLES = 8 + TXN_TOTAL * TXN_CYCLES;

  logic                           clk;
  logic                           rst;
  logic                           host_req;
  scratch_pkg::host_cmd_t         host_cmd;
  logic                           host_busy;
  logic                           host_done;
  logic [scratch_pkg::DATA_W-1:0] host_rdata;
  logic                           sum_start;
  scratch_pkg::sum_cmd_t          sum_cmd;
  logic                           sum_busy;
  logic                           sum_done;
  logic [scratch_pkg::DATA_W-1:0] sum_result;

  int seed = 78;
  int tb_errors;
  int errs_before;
  int host_before;
  int sum_before;
  int base;

  scratch_top u_dut (
    .clk (clk), .rst (rst),
    .host_req (host_req), .host_cmd (host_cmd), .host_busy (host_busy),
    .host_done (host_done), .host_rdata (host_rdata),
    .sum_start (sum_start), .sum_cmd (sum_cmd), .sum_busy (sum_busy),
    .sum_done (sum_done), .sum_result (sum_result)
  );

  scratch_monitor u_mon (
    .clk (clk), .rst (rst),
    .host_req (host_req), .host_cmd (host_cmd), .host_busy (host_busy),
    .host_done (host_done), .host_rdata (host_rdata),
    .sum_start (sum_start), .sum_cmd (sum_cmd), .sum_busy (sum_busy),
    .sum_done (sum_done), .sum_result (sum_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int total_errors();
    return tb_errors + u_mon.err_count;
  endfunction

  // Called 1 ns after a rising edge, returns there too
  task automatic host_op(input logic write, input logic [`SCRATCH_LANES-1:0] mask,
                         input int addr, input logic [31:0] data);
    int waited;
    waited = 0;
    while (host_busy && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1 waited++;
    end
    host_cmd.write = write;
    host_cmd.mask  = mask;
    host_cmd.addr  = AW'(addr);
    host_cmd.data  = data;
    host_req       = 1'b1;
    @(posedge clk);
    #1 host_req = 1'b0;
    waited = 0;
    while (!host_done && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1 waited++;
    end
    if (!host_done) begin
      tb_errors++;
      $display("Host command to word %0d never completed by time %0t", addr, $time);
    end
    @(posedge clk);  // Monitor samples the done cycle first
    #1;
  endtask

  task automatic sum_job(input int job_base, input int count);
    int waited;
    waited = 0;
    while (sum_busy && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1 waited++;
    end
    sum_cmd.base  = AW'(job_base);
    sum_cmd.count = AW'(count);
    sum_start     = 1'b1;
    @(posedge clk);
    #1 sum_start = 1'b0;
    waited = 0;
    while (!sum_done && waited < WAIT_LIMIT * (count + 1)) begin
      @(posedge clk);
      #1 waited++;
    end
    if (!sum_done) begin
      tb_errors++;
      $display("Sum job of %0d words from %0d never finished by time %0t",
               count, job_base, $time);
    end
    @(posedge clk);  // Monitor samples the done cycle first
    #1;
  endtask

  task automatic report_test(input string name, input int txns);
    $display("Test %s: %0d transactions, %0d errors", name, txns, total_errors() - errs_before);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    host_req  = 1'b0;
    host_cmd  = '0;
    sum_start = 1'b0;
    sum_cmd   = '0;
    tb_errors = 0;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;

    errs_before = total_errors();
    if (host_busy || host_done || sum_busy || sum_done) begin
      tb_errors++;
      $display("[ERROR] %0t: status outputs not all low after reset", $time);
    end
    report_test("1 reset state", 1);

    errs_before = total_errors();
    for (int i = 0; i < N_WORDS; i++) host_op(1'b1, '1, i, $random(seed));
    for (int i = N_WORDS - 1; i >= 0; i--) host_op(1'b0, '0, i, '0);  // Reverse order
    report_test("2 full-word write and read", 2 * N_WORDS);

    errs_before = total_errors();
    for (int i = 0; i < N_MASK; i++) begin
      base = rand_below(N_WORDS);
      host_op(1'b1, `SCRATCH_LANES'($random(seed)), base, $random(seed));
      host_op(1'b0, '0, base, '0);
    end
    report_test("3 masked writes", 2 * N_MASK);

    errs_before = total_errors();
    sum_job(rand_below(N_WORDS), 0);  // Empty range first
    for (int j = 1; j < N_SUM; j++) begin
      base = rand_below(N_WORDS);
      sum_job(base, 1 + rand_below(N_WORDS - base));
    end
    report_test("4 range sums", N_SUM);

    errs_before = total_errors();
    host_before = u_mon.host_done_count;
    sum_before  = u_mon.sum_done_count;
    fork
      sum_job(0, N_WORDS);
      for (int k = 0; k < N_MIX; k++) begin
        host_op(rand_below(2) == 1, `SCRATCH_LANES'($random(seed)),
                MIX_BASE + rand_below(64), $random(seed));
      end
    join
    if (u_mon.host_done_count - host_before != N_MIX ||
        u_mon.sum_done_count - sum_before != 1) begin
      tb_errors++;
      $display("Commands were lost under arbitration, %0d host and %0d sum completions",
               u_mon.host_done_count - host_before, u_mon.sum_done_count - sum_before);
    end
    report_test("5 host traffic during a sum", N_MIX + 1);

    $display("Done: %0d monitor checks, %0d errors", u_mon.check_count, total_errors());
    if (total_errors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+source
source/scratch_pkg.sv
source/byte_ram.sv
source/ram_arbiter.sv
source/host_port.sv
source/sum_engine.sv
source/scratch_top.sv
test/byte_ram_chk.sv
test/scratch_monitor.sv
test/scratch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, from the project root
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module scratch_tb -Mdir "$OBJ" -o scratch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/scratch_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
